// File: files.f
+incdir+logic
logic/bullet_pkg.sv
logic/bullet_flight.sv
logic/bullet_resolver.sv
logic/bullet_duel_top.sv
sim/bullet_duel_chk.sv
sim/bullet_duel_tb.sv

// File: logic/bullet_defs.svh
`ifndef BULLET_DEFS_SVH
`define BULLET_DEFS_SVH

// ----------------------------------------
// battle field geometry
// ----------------------------------------

// field width in cells, x runs 0..15
`define GRID_W 16

// field height in cells, y runs 0..19
`define GRID_H 20

// bits per coordinate
// must cover the larger of the two sizes
`define CELL_W 5

`endif

// File: logic/bullet_duel_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "bullet_defs.svh"

module bullet_duel_top
	import bullet_pkg::*;
(
	input  logic              clk_8Hz,
	input  logic              rst,
	input  logic              p_fire,
	input  logic              e_fire,
	input  dir_e              p_dir,
	input  dir_e              e_dir,
	input  logic [`CELL_W-1:0] p_tank_x,
	input  logic [`CELL_W-1:0] p_tank_y,
	input  logic [`CELL_W-1:0] e_tank_x,
	input  logic [`CELL_W-1:0] e_tank_y,
	output logic [`CELL_W-1:0] p_bul_x,
	output logic [`CELL_W-1:0] p_bul_y,
	output logic [`CELL_W-1:0] e_bul_x,
	output logic [`CELL_W-1:0] e_bul_y,
	output logic              p_active,
	output logic              e_active,
	output logic              p_hit,
	output logic              e_hit,
	output logic              clash
);

	// kills from the resolver, same cycle
	logic p_kill;
	logic e_kill;

	// ----------------------------------------
	// player bullet
	// ----------------------------------------
	bullet_flight p_flight_i (
		.clk_8Hz (clk_8Hz),
		.rst     (rst),
		.fire    (p_fire),
		.kill    (p_kill),
		.dir     (p_dir),
		.tank_x  (p_tank_x),
		.tank_y  (p_tank_y),
		.bul_x   (p_bul_x),
		.bul_y   (p_bul_y),
		.active  (p_active)
	);

	// ----------------------------------------
	// enemy bullet
	// ----------------------------------------
	bullet_flight e_flight_i (
		.clk_8Hz (clk_8Hz),
		.rst     (rst),
		.fire    (e_fire),
		.kill    (e_kill),
		.dir     (e_dir),
		.tank_x  (e_tank_x),
		.tank_y  (e_tank_y),
		.bul_x   (e_bul_x),
		.bul_y   (e_bul_y),
		.active  (e_active)
	);

	// ----------------------------------------
	// hits and clashes for both sides
	// ----------------------------------------
	bullet_resolver resolver_i (
		.clk_8Hz  (clk_8Hz),
		.rst      (rst),
		.p_bul_x  (p_bul_x),
		.p_bul_y  (p_bul_y),
		.e_bul_x  (e_bul_x),
		.e_bul_y  (e_bul_y),
		.p_tank_x (p_tank_x),
		.p_tank_y (p_tank_y),
		.e_tank_x (e_tank_x),
		.e_tank_y (e_tank_y),
		.p_active (p_active),
		.e_active (e_active),
		.p_kill   (p_kill),
		.e_kill   (e_kill),
		.p_hit    (p_hit),
		.e_hit    (e_hit),
		.clash    (clash)
	);

endmodule

`default_nettype wire

// File: logic/bullet_flight.sv
`timescale 1ns/1ns
`default_nettype none

`include "bullet_defs.svh"

module bullet_flight
	import bullet_pkg::*;
(
	input  logic              clk_8Hz,
	input  logic              rst,
	input  logic              fire,
	input  logic              kill,
	input  dir_e              dir,
	input  logic [`CELL_W-1:0] tank_x,
	input  logic [`CELL_W-1:0] tank_y,
	output logic [`CELL_W-1:0] bul_x,
	output logic [`CELL_W-1:0] bul_y,
	output logic              active
);

	// last legal cell on each axis
	localparam logic [`CELL_W-1:0] x_last = `CELL_W'(`GRID_W - 1);
	localparam logic [`CELL_W-1:0] y_last = `CELL_W'(`GRID_H - 1);

	// bullet state
	cell_word_u pos_q;
	cell_word_u pos_step;
	dir_e       dir_q;
	logic       active_q;

	// next step would cross the border
	logic       leaving;

	// ----------------------------------------
	// border test on the latched direction
	// ----------------------------------------
	always_comb
	begin
		leaving = 1'b0;
		case (dir_q)
			dir_up:    leaving = (pos_q.xy.y == '0);
			dir_down:  leaving = (pos_q.xy.y == y_last);
			dir_left:  leaving = (pos_q.xy.x == '0);
			dir_right: leaving = (pos_q.xy.x == x_last);
			default:   leaving = 1'b1;
		endcase
	end

	// ----------------------------------------
	// one cell step, only used when not leaving
	// ----------------------------------------
	always_comb
	begin
		pos_step = pos_q;
		case (dir_q)
			dir_up:    pos_step.xy.y = pos_q.xy.y - 1'b1;
			dir_down:  pos_step.xy.y = pos_q.xy.y + 1'b1;
			dir_left:  pos_step.xy.x = pos_q.xy.x - 1'b1;
			dir_right: pos_step.xy.x = pos_q.xy.x + 1'b1;
			default:   pos_step = pos_q;
		endcase
	end

	// ----------------------------------------
	// launch, move, die
	// ----------------------------------------
	always_ff @(posedge clk_8Hz)
	begin
		if (rst)
		begin
			active_q  <= 1'b0;
			pos_q.key <= '0;
			dir_q     <= dir_up;
		end
		else if (kill)
		begin
			// resolver decided a hit or clash, position frozen
			active_q <= 1'b0;
		end
		else if (active_q)
		begin
			// outward step ends the flight instead of wrapping
			if (leaving)
				active_q <= 1'b0;
			else
				pos_q <= pos_step;
		end
		else if (fire)
		begin
			// launch from the tank cell
			active_q    <= 1'b1;
			pos_q.xy.x  <= tank_x;
			pos_q.xy.y  <= tank_y;
			dir_q       <= dir;
		end
	end

	// outputs straight from the registers
	assign bul_x  = pos_q.xy.x;
	assign bul_y  = pos_q.xy.y;
	assign active = active_q;

endmodule

`default_nettype wire

// File: logic/bullet_pkg.sv
`default_nettype none

`include "bullet_defs.svh"

package bullet_pkg;

	// firing direction, screen orientation
	// up means y gets smaller
	typedef enum logic [1:0] {
		dir_up    = 2'd0,
		dir_down  = 2'd1,
		dir_left  = 2'd2,
		dir_right = 2'd3
	} dir_e;

	// one grid cell as a coordinate pair
	typedef struct packed {
		logic [`CELL_W-1:0] x;
		logic [`CELL_W-1:0] y;
	} cell_xy_t;

	// same cell word, two readings
	// xy for motion and bounds, key for equality tests
	typedef union packed {
		cell_xy_t               xy;
		logic [2*`CELL_W-1:0]   key;
	} cell_word_u;

endpackage

`default_nettype wire

// File: logic/bullet_resolver.sv
`timescale 1ns/1ns
`default_nettype none

`include "bullet_defs.svh"

module bullet_resolver
	import bullet_pkg::*;
(
	input  logic              clk_8Hz,
	input  logic              rst,
	input  logic [`CELL_W-1:0] p_bul_x,
	input  logic [`CELL_W-1:0] p_bul_y,
	input  logic [`CELL_W-1:0] e_bul_x,
	input  logic [`CELL_W-1:0] e_bul_y,
	input  logic [`CELL_W-1:0] p_tank_x,
	input  logic [`CELL_W-1:0] p_tank_y,
	input  logic [`CELL_W-1:0] e_tank_x,
	input  logic [`CELL_W-1:0] e_tank_y,
	input  logic              p_active,
	input  logic              e_active,
	output logic              p_kill,
	output logic              e_kill,
	output logic              p_hit,
	output logic              e_hit,
	output logic              clash
);

	// pack a coordinate pair into one cell word
	function automatic cell_word_u pack_cell(
		input logic [`CELL_W-1:0] x,
		input logic [`CELL_W-1:0] y
	);
		cell_word_u w;
		w.xy.x = x;
		w.xy.y = y;
		return w;
	endfunction

	// cell words of both bullets and both tanks
	cell_word_u p_bul_w;
	cell_word_u e_bul_w;
	cell_word_u p_tank_w;
	cell_word_u e_tank_w;

	// events seen in the current cycle
	logic clash_now;
	logic p_hit_now;
	logic e_hit_now;

	assign p_bul_w  = pack_cell(p_bul_x, p_bul_y);
	assign e_bul_w  = pack_cell(e_bul_x, e_bul_y);
	assign p_tank_w = pack_cell(p_tank_x, p_tank_y);
	assign e_tank_w = pack_cell(e_tank_x, e_tank_y);

	// ----------------------------------------
	// coincidence tests on the flat key
	// ----------------------------------------

	// both bullets share a cell
	// swapping cells in one tick is not seen here
	assign clash_now = p_active && e_active && (p_bul_w.key == e_bul_w.key);

	// player bullet on enemy tank
	assign e_hit_now = p_active && (p_bul_w.key == e_tank_w.key);

	// enemy bullet on player tank
	assign p_hit_now = e_active && (e_bul_w.key == p_tank_w.key);

	// a bullet never tests against its own tank
	// it sits there right after launch

	// ----------------------------------------
	// kills go back to the flight units now
	// ----------------------------------------
	assign p_kill = clash_now || e_hit_now;
	assign e_kill = clash_now || p_hit_now;

	// ----------------------------------------
	// event pulses, one cycle after the match
	// ----------------------------------------
	always_ff @(posedge clk_8Hz)
	begin
		if (rst)
		begin
			p_hit <= 1'b0;
			e_hit <= 1'b0;
			clash <= 1'b0;
		end
		else
		begin
			// bullets die on the same edge, so no repeat
			p_hit <= p_hit_now;
			e_hit <= e_hit_now;
			clash <= clash_now;
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module bullet_duel_tb -f files.f -o bullet_duel_sim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/bullet_duel_sim > sim.log 2>&1 || true
cat sim.log
grep -q "RESULT: PASS" sim.log && exit 0 || exit 1

// File: sim/bullet_duel_chk.sv
`timescale 1ns/1ns
`default_nettype none

`include "bullet_defs.svh"

module bullet_duel_chk (
	input wire logic              clk_8Hz,
	input wire logic              rst,
	input wire logic              p_kill,
	input wire logic              e_kill,
	input wire logic              p_active,
	input wire logic              e_active,
	input wire logic              p_hit,
	input wire logic              e_hit,
	input wire logic              clash,
	input wire logic [`CELL_W-1:0] p_bul_x,
	input wire logic [`CELL_W-1:0] p_bul_y,
	input wire logic [`CELL_W-1:0] e_bul_x,
	input wire logic [`CELL_W-1:0] e_bul_y
);

	// ----------------------------------------
	// event pulses last one cycle
	// ----------------------------------------
	a_p_hit_pulse: assert property (@(posedge clk_8Hz) disable iff (rst) p_hit |=> !p_hit)
		else $error("p_hit held longer than one cycle");
	a_e_hit_pulse: assert property (@(posedge clk_8Hz) disable iff (rst) e_hit |=> !e_hit)
		else $error("e_hit held longer than one cycle");
	a_clash_pulse: assert property (@(posedge clk_8Hz) disable iff (rst) clash |=> !clash)
		else $error("clash held longer than one cycle");

	// a killed bullet is gone next cycle
	a_p_kill: assert property (@(posedge clk_8Hz) disable iff (rst) p_kill |=> !p_active)
		else $error("player bullet alive after kill");
	a_e_kill: assert property (@(posedge clk_8Hz) disable iff (rst) e_kill |=> !e_active)
		else $error("enemy bullet alive after kill");

	// in-field while flying
	a_p_inside: assert property (@(posedge clk_8Hz)
		p_active |-> (p_bul_x < `CELL_W'(`GRID_W)) && (p_bul_y < `CELL_W'(`GRID_H)))
		else $error("player bullet outside the field");
	a_e_inside: assert property (@(posedge clk_8Hz)
		e_active |-> (e_bul_x < `CELL_W'(`GRID_W)) && (e_bul_y < `CELL_W'(`GRID_H)))
		else $error("enemy bullet outside the field");

	// reset clears both bullets
	a_rst: assert property (@(posedge clk_8Hz) rst |=> !p_active && !e_active)
		else $error("bullet active after reset");

endmodule

bind bullet_duel_top bullet_duel_chk chk_i (.*);

`default_nettype wire

// File: sim/bullet_duel_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "bullet_defs.svh"

module bullet_duel_tb
	import bullet_pkg::*;
;

	// one bullet in the model
	typedef struct packed {
		logic [`CELL_W-1:0] x;
		logic [`CELL_W-1:0] y;
		logic [1:0]         d;
		logic               a;
	} bul_t;

	// whole model state with the pulses
	typedef struct packed {
		bul_t p;
		bul_t e;
		logic ph;
		logic eh;
		logic cl;
	} model_t;

	// DUT inputs
	logic clk_8Hz = 1'b0;
	logic rst = 1'b1;
	logic p_fire = 1'b0;
	logic e_fire = 1'b0;
	dir_e p_dir = dir_up;
	dir_e e_dir = dir_up;
	logic [`CELL_W-1:0] p_tank_x = '0;
	logic [`CELL_W-1:0] p_tank_y = '0;
	logic [`CELL_W-1:0] e_tank_x = '0;
	logic [`CELL_W-1:0] e_tank_y = '0;

	// DUT outputs
	logic [`CELL_W-1:0] p_bul_x;
	logic [`CELL_W-1:0] p_bul_y;
	logic [`CELL_W-1:0] e_bul_x;
	logic [`CELL_W-1:0] e_bul_y;
	logic p_active;
	logic e_active;
	logic p_hit;
	logic e_hit;
	logic clash;

	// expected state and counters
	model_t m;
	integer errors = 0;
	integer tests = 0;
	integer seed = 25196;
	logic saw_clash;

	bullet_duel_top dut_i (.*);

	always #4 clk_8Hz = ~clk_8Hz;

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	// one bullet over one edge
	// rule order kill, border, step, launch
	function automatic bul_t advance(bul_t b, logic kill, logic fire, logic [1:0] fd,
		logic [`CELL_W-1:0] tx, logic [`CELL_W-1:0] ty);
		bul_t n;
		logic edge_hit;
		n = b;
		// outward step from a border cell
		edge_hit = (b.d == 2'd0 && b.y == '0) ||
			(b.d == 2'd1 && b.y == `CELL_W'(`GRID_H - 1)) ||
			(b.d == 2'd2 && b.x == '0) ||
			(b.d == 2'd3 && b.x == `CELL_W'(`GRID_W - 1));
		if (kill)
			n.a = 1'b0;
		else if (b.a && edge_hit)
			n.a = 1'b0;
		else if (b.a)
		begin
			// up and left count down
			case (b.d)
				2'd0: n.y = b.y - 1'b1;
				2'd1: n.y = b.y + 1'b1;
				2'd2: n.x = b.x - 1'b1;
				2'd3: n.x = b.x + 1'b1;
			endcase
		end
		else if (fire)
		begin
			n.a = 1'b1;
			n.x = tx;
			n.y = ty;
			n.d = fd;
		end
		return n;
	endfunction

	// reference for the next edge
	function automatic model_t next_model(model_t s);
		model_t n;
		logic cl_now;
		logic eh_now;
		logic ph_now;
		// coincidences on the current cells
		cl_now = s.p.a && s.e.a && s.p.x == s.e.x && s.p.y == s.e.y;
		eh_now = s.p.a && s.p.x == e_tank_x && s.p.y == e_tank_y;
		ph_now = s.e.a && s.e.x == p_tank_x && s.e.y == p_tank_y;
		n.p = advance(s.p, cl_now || eh_now, p_fire, p_dir, p_tank_x, p_tank_y);
		n.e = advance(s.e, cl_now || ph_now, e_fire, e_dir, e_tank_x, e_tank_y);
		n.ph = ph_now;
		n.eh = eh_now;
		n.cl = cl_now;
		return n;
	endfunction

	always @(posedge clk_8Hz)
	begin
		if (rst)
			m <= '0;
		else
			m <= next_model(m);
	end

	// ----------------------------------------
	// compare against the model
	// ----------------------------------------
	task automatic check_val(string name, logic [`CELL_W-1:0] got, logic [`CELL_W-1:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
			errors = errors + 1;
		end
	endtask

	// every output mid cycle
	always @(negedge clk_8Hz)
	begin
		check_val("p_bul_x", p_bul_x, m.p.x);
		check_val("p_bul_y", p_bul_y, m.p.y);
		check_val("e_bul_x", e_bul_x, m.e.x);
		check_val("e_bul_y", e_bul_y, m.e.y);
		check_val("p_active", 5'(p_active), 5'(m.p.a));
		check_val("e_active", 5'(e_active), 5'(m.e.a));
		check_val("p_hit", 5'(p_hit), 5'(m.ph));
		check_val("e_hit", 5'(e_hit), 5'(m.eh));
		check_val("clash", 5'(clash), 5'(m.cl));
	end

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------

	// next edge, then drop the strobes
	task automatic tick();
		@(posedge clk_8Hz);
		#1;
		p_fire = 1'b0;
		e_fire = 1'b0;
	endtask

	task automatic set_tanks(integer px, integer py, integer ex, integer ey);
		p_tank_x = `CELL_W'(px);
		p_tank_y = `CELL_W'(py);
		e_tank_x = `CELL_W'(ex);
		e_tank_y = `CELL_W'(ey);
	endtask

	// wait until both bullets are gone
	// a fire strobe mid flight must be ignored
	task automatic wait_idle(string what);
		integer n;
		saw_clash = 1'b0;
		tick();
		for (n = 0; n < 60 && (p_active || e_active); n = n + 1)
		begin
			if (n == 3)
				p_fire = 1'b1;
			tick();
			saw_clash = saw_clash | clash;
		end
		if (p_active || e_active)
		begin
			$display("%s: bullets never left the field", what);
			errors = errors + 1;
		end
	endtask

	task automatic wait_pulse(ref logic sig, input string what);
		integer n;
		for (n = 0; n < 60 && !sig; n = n + 1)
			tick();
		if (!sig)
		begin
			$display("%s: expected pulse never came", what);
			errors = errors + 1;
		end
		tick();
	endtask

	task automatic finish_test(string what);
		tests = tests + 1;
		$display("test %0d %s done, errors so far %0d", tests, what, errors);
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial
	begin
		integer i;
		logic [31:0] r;
		repeat (5) @(posedge clk_8Hz);
		#1;
		rst = 1'b0;
		tick();
		finish_test("reset");

		// each direction from the middle
		// enemy tank off the path
		set_tanks(8, 10, 15, 0);
		for (i = 0; i < 4; i = i + 1)
		begin
			p_dir = dir_e'(i);
			p_fire = 1'b1;
			wait_idle("direction");
		end
		finish_test("directions and border");

		// player down onto enemy then enemy up onto player
		set_tanks(3, 5, 3, 15);
		p_dir = dir_down;
		p_fire = 1'b1;
		wait_pulse(e_hit, "e_hit");
		wait_idle("after e_hit");
		e_dir = dir_up;
		e_fire = 1'b1;
		wait_pulse(p_hit, "p_hit");
		wait_idle("after p_hit");
		finish_test("hits");

		// even gap meets on a cell
		// tanks leave the row after launch
		set_tanks(2, 4, 8, 4);
		p_dir = dir_right;
		e_dir = dir_left;
		p_fire = 1'b1;
		e_fire = 1'b1;
		tick();
		set_tanks(0, 19, 15, 19);
		wait_pulse(clash, "clash");
		wait_idle("after clash");
		finish_test("clash");

		// odd gap swaps cells and passes through
		set_tanks(2, 4, 7, 4);
		p_fire = 1'b1;
		e_fire = 1'b1;
		tick();
		set_tanks(0, 19, 15, 19);
		wait_idle("swap");
		if (saw_clash)
		begin
			$display("swap: bullets passing through gave a clash");
			errors = errors + 1;
		end
		finish_test("swap");

		// random strobes, directions and tank cells
		for (i = 0; i < 500; i = i + 1)
		begin
			r = $random(seed);
			p_fire = r[0] & r[1];
			e_fire = r[2] & r[3];
			p_dir = dir_e'(r[5:4]);
			e_dir = dir_e'(r[7:6]);
			if (r[8])
				set_tanks(int'(r[12:9]), int'(r[31:16]) % 20,
					int'(r[27:24]), int'(r[23:16]) % 20);
			tick();
		end
		finish_test("random");

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
